// ==== include/roce_meta_settings.svh ====
// Field widths and bit offsets of the RoCE core metadata words
`ifndef ROCE_META_SETTINGS_SVH
`define ROCE_META_SETTINGS_SVH

// Field widths
`define RDMA_OPCODE_BITS 5
`define PID_BITS 6
`define DEST_BITS 4
`define STRM_BITS 2
`define RDMA_QPN_BITS 24
`define VADDR_BITS 48
`define RDMA_VADDR_BITS 64
`define LEN_BITS 28
`define RDMA_LEN_BITS 32
`define OFFS_BITS 6
`define RDMA_IMM_BITS 32
`define ECN_BITS 1

// Flat word widths
`define RDMA_REQ_BITS 256
`define RDMA_ACK_BITS 96
`define RDMA_BASE_REQ_BITS 160

// QPN starts at bit 32 in every word
`define RDMA_QPN_OFFS 32
`define RDMA_QPN_PAD_BITS (`RDMA_QPN_BITS - `DEST_BITS - `PID_BITS)

// Send-queue word
`define SQ_HOST_OFFS (`RDMA_QPN_OFFS + `RDMA_QPN_BITS)
`define SQ_LAST_OFFS (`SQ_HOST_OFFS + 1)
`define SQ_OFFS_OFFS (`SQ_LAST_OFFS + 1)
`define SQ_LVADDR_OFFS (`SQ_OFFS_OFFS + `OFFS_BITS)
`define SQ_RVADDR_OFFS (`SQ_LVADDR_OFFS + `RDMA_VADDR_BITS)
`define SQ_LEN_OFFS (`SQ_RVADDR_OFFS + `RDMA_VADDR_BITS)
`define SQ_IMM_OFFS (`SQ_LEN_OFFS + `RDMA_LEN_BITS)
`define SQ_LVADDR_PAD_BITS (`RDMA_VADDR_BITS - `VADDR_BITS)
`define SQ_RVADDR_PAD_BITS (`RDMA_VADDR_BITS - `VADDR_BITS - `DEST_BITS - `STRM_BITS)
// Remote offset bits that fit above remote len in the immediate
`define SQ_IMM_OFFS_BITS (`RDMA_IMM_BITS - `LEN_BITS)

// Ack word
`define ACK_HOST_OFFS (`RDMA_QPN_OFFS + `RDMA_QPN_BITS)
`define ACK_DEST_OFFS (`ACK_HOST_OFFS + 1)
`define ACK_STRM_OFFS (`ACK_DEST_OFFS + `DEST_BITS)
`define ACK_LAST_OFFS (`ACK_STRM_OFFS + `STRM_BITS)
`define ACK_ECN_OFFS (`ACK_LAST_OFFS + 1)

// Memory command word
`define CMD_LAST_OFFS (`RDMA_QPN_OFFS + `RDMA_QPN_BITS)
`define CMD_VADDR_OFFS (`CMD_LAST_OFFS + 1)
`define CMD_DEST_OFFS (`CMD_VADDR_OFFS + `VADDR_BITS)
`define CMD_STRM_OFFS (`CMD_DEST_OFFS + `DEST_BITS)
`define CMD_LEN_OFFS (`CMD_STRM_OFFS + `STRM_BITS)
`define CMD_ACTV_OFFS (`CMD_LEN_OFFS + `LEN_BITS)
`define CMD_HOST_OFFS (`CMD_ACTV_OFFS + 1)
`define CMD_OFFS_OFFS (`CMD_HOST_OFFS + 1)

`endif

// ==== src/roce_meta_pkg.sv ====
// Queue-pair number views shared by the send-queue encoder and the decoders
`default_nettype none

`include "roce_meta_settings.svh"

package roce_meta_pkg;

  // QPN as the core sees it
  // Pad on top, then vfid, pid in the low bits
  typedef struct packed {
    logic [`RDMA_QPN_PAD_BITS-1:0] pad;
    logic [`DEST_BITS-1:0]         vfid;
    logic [`PID_BITS-1:0]          pid;
  } qpn_fields_t;

  // Same 24 bits, raw or split
  typedef union packed {
    logic [`RDMA_QPN_BITS-1:0] raw;
    qpn_fields_t               fields;
  } qpn_u;

endpackage

`default_nettype wire

// ==== src/sq_encoder.sv ====
// Send-queue encoder, packs a user request into the flat core send-queue word
`timescale 1ns/1ps
`default_nettype none

`include "roce_meta_settings.svh"

module sq_encoder (
  input  logic                            nclk,
  input  logic                            arst_n,
  // User request, first half
  input  logic                            sq_valid,
  input  logic [`RDMA_OPCODE_BITS-1:0]    sq_opcode,
  input  logic [`PID_BITS-1:0]            sq_pid,
  input  logic [`DEST_BITS-1:0]           sq_vfid,
  input  logic                            sq_host,
  input  logic                            sq_last,
  input  logic [`OFFS_BITS-1:0]           sq_offs,
  input  logic [`VADDR_BITS-1:0]          sq_vaddr,
  input  logic [`DEST_BITS-1:0]           sq_dest,
  input  logic [`RDMA_LEN_BITS-1:0]       sq_len,
  // Remote half
  input  logic [`STRM_BITS-1:0]           sq_strm,
  input  logic [`VADDR_BITS-1:0]          sq_remote_vaddr,
  input  logic [`OFFS_BITS-1:0]           sq_remote_offs,
  input  logic [`LEN_BITS-1:0]            sq_remote_len,
  // Core side
  output logic                            core_sq_valid,
  output logic [`RDMA_REQ_BITS-1:0]       core_sq_data
);

  roce_meta_pkg::qpn_u            sq_qpn;
  logic [`RDMA_REQ_BITS-1:0]      sq_word;

  always_comb begin
    // QPN with pad cleared
    sq_qpn             = '0;
    sq_qpn.fields.vfid = sq_vfid;
    sq_qpn.fields.pid  = sq_pid;

    // Anything not written below stays zero
    sq_word = '0;
    sq_word[0 +: `RDMA_OPCODE_BITS]            = sq_opcode;
    sq_word[`RDMA_QPN_OFFS +: `RDMA_QPN_BITS]  = sq_qpn.raw;
    sq_word[`SQ_HOST_OFFS]                     = sq_host;
    sq_word[`SQ_LAST_OFFS]                     = sq_last;
    sq_word[`SQ_OFFS_OFFS +: `OFFS_BITS]       = sq_offs;
    // Local vaddr, zero extended to 64
    sq_word[`SQ_LVADDR_OFFS +: `RDMA_VADDR_BITS] =
      {{`SQ_LVADDR_PAD_BITS{1'b0}}, sq_vaddr};
    // Remote vaddr word carries strm and dest above the address
    sq_word[`SQ_RVADDR_OFFS +: `RDMA_VADDR_BITS] =
      {{`SQ_RVADDR_PAD_BITS{1'b0}}, sq_strm, sq_dest, sq_remote_vaddr};
    sq_word[`SQ_LEN_OFFS +: `RDMA_LEN_BITS]    = sq_len;
    // Immediate holds low remote offs bits over remote len
    sq_word[`SQ_IMM_OFFS +: `RDMA_IMM_BITS]    =
      {sq_remote_offs[`SQ_IMM_OFFS_BITS-1:0], sq_remote_len};
  end

  // One register stage, word loads only on a strobe
  always_ff @(posedge nclk or negedge arst_n) begin
    if (!arst_n) begin
      core_sq_valid <= 1'b0;
      core_sq_data  <= '0;
    end else begin
      core_sq_valid <= sq_valid;
      if (sq_valid) begin
        core_sq_data <= sq_word;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/mem_cmd_decoder.sv ====
// Memory command decoder, splits a flat core read or write command into request fields
`timescale 1ns/1ps
`default_nettype none

`include "roce_meta_settings.svh"

module mem_cmd_decoder (
  input  logic                            nclk,
  input  logic                            arst_n,
  // Core command
  input  logic                            cmd_valid,
  input  logic [`RDMA_BASE_REQ_BITS-1:0]  cmd_data,
  // Decoded request
  output logic                            req_valid,
  output logic [`RDMA_OPCODE_BITS-1:0]    req_opcode,
  output logic [`PID_BITS-1:0]            req_pid,
  output logic [`DEST_BITS-1:0]           req_vfid,
  output logic                            req_last,
  output logic [`VADDR_BITS-1:0]          req_vaddr,
  output logic [`DEST_BITS-1:0]           req_dest,
  output logic [`STRM_BITS-1:0]           req_strm,
  output logic [`LEN_BITS-1:0]            req_len,
  output logic                            req_actv,
  output logic                            req_host,
  output logic [`OFFS_BITS-1:0]           req_offs
);

  roce_meta_pkg::qpn_u cmd_qpn;

  // QPN read through the split view
  // Pad above vfid goes nowhere
  assign cmd_qpn.raw = cmd_data[`RDMA_QPN_OFFS +: `RDMA_QPN_BITS];

  always_ff @(posedge nclk or negedge arst_n) begin
    if (!arst_n) begin
      req_valid  <= 1'b0;
      req_opcode <= '0;
      req_pid    <= '0;
      req_vfid   <= '0;
      req_last   <= 1'b0;
      req_vaddr  <= '0;
      req_dest   <= '0;
      req_strm   <= '0;
      req_len    <= '0;
      req_actv   <= 1'b0;
      req_host   <= 1'b0;
      req_offs   <= '0;
    end else begin
      req_valid <= cmd_valid;
      // Fields hold until the next command
      if (cmd_valid) begin
        req_opcode <= cmd_data[0 +: `RDMA_OPCODE_BITS];
        req_pid    <= cmd_qpn.fields.pid;
        req_vfid   <= cmd_qpn.fields.vfid;
        req_last   <= cmd_data[`CMD_LAST_OFFS];
        req_vaddr  <= cmd_data[`CMD_VADDR_OFFS +: `VADDR_BITS];
        req_dest   <= cmd_data[`CMD_DEST_OFFS +: `DEST_BITS];
        req_strm   <= cmd_data[`CMD_STRM_OFFS +: `STRM_BITS];
        req_len    <= cmd_data[`CMD_LEN_OFFS +: `LEN_BITS];
        req_actv   <= cmd_data[`CMD_ACTV_OFFS];
        req_host   <= cmd_data[`CMD_HOST_OFFS];
        req_offs   <= cmd_data[`CMD_OFFS_OFFS +: `OFFS_BITS];
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/ack_decoder.sv ====
// Ack decoder, slices the flat core ack word into user completion fields
`timescale 1ns/1ps
`default_nettype none

`include "roce_meta_settings.svh"

module ack_decoder (
  input  logic                            nclk,
  input  logic                            arst_n,
  // Core ack
  input  logic                            core_ack_valid,
  input  logic [`RDMA_ACK_BITS-1:0]       core_ack_data,
  // User completion
  output logic                            ack_valid,
  output logic [`RDMA_OPCODE_BITS-1:0]    ack_opcode,
  output logic [`PID_BITS-1:0]            ack_pid,
  output logic [`DEST_BITS-1:0]           ack_vfid,
  output logic                            ack_host,
  output logic [`DEST_BITS-1:0]           ack_dest,
  output logic [`STRM_BITS-1:0]           ack_strm,
  output logic                            ack_last,
  output logic [`ECN_BITS-1:0]            ack_ecn
);

  roce_meta_pkg::qpn_u ack_qpn;

  // pid and vfid sit in the low QPN bits
  assign ack_qpn.raw = core_ack_data[`RDMA_QPN_OFFS +: `RDMA_QPN_BITS];

  always_ff @(posedge nclk or negedge arst_n) begin
    if (!arst_n) begin
      ack_valid  <= 1'b0;
      ack_opcode <= '0;
      ack_pid    <= '0;
      ack_vfid   <= '0;
      ack_host   <= 1'b0;
      ack_dest   <= '0;
      ack_strm   <= '0;
      ack_last   <= 1'b0;
      ack_ecn    <= '0;
    end else begin
      ack_valid <= core_ack_valid;
      if (core_ack_valid) begin
        ack_opcode <= core_ack_data[0 +: `RDMA_OPCODE_BITS];
        ack_pid    <= ack_qpn.fields.pid;
        ack_vfid   <= ack_qpn.fields.vfid;
        ack_host   <= core_ack_data[`ACK_HOST_OFFS];
        ack_dest   <= core_ack_data[`ACK_DEST_OFFS +: `DEST_BITS];
        ack_strm   <= core_ack_data[`ACK_STRM_OFFS +: `STRM_BITS];
        ack_last   <= core_ack_data[`ACK_LAST_OFFS];
        // Congestion mark right after last
        ack_ecn    <= core_ack_data[`ACK_ECN_OFFS +: `ECN_BITS];
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/roce_meta_shim.sv ====
// RoCE metadata shim top, send-queue encoder, read and write command decoders, ack decoder
`timescale 1ns/1ps
`default_nettype none

`include "roce_meta_settings.svh"

module roce_meta_shim (
  input  logic                            nclk,
  input  logic                            arst_n,
  // User send-queue request
  input  logic                            sq_valid,
  input  logic [`RDMA_OPCODE_BITS-1:0]    sq_opcode,
  input  logic [`PID_BITS-1:0]            sq_pid,
  input  logic [`DEST_BITS-1:0]           sq_vfid,
  input  logic                            sq_host,
  input  logic                            sq_last,
  input  logic [`OFFS_BITS-1:0]           sq_offs,
  input  logic [`VADDR_BITS-1:0]          sq_vaddr,
  input  logic [`DEST_BITS-1:0]           sq_dest,
  input  logic [`STRM_BITS-1:0]           sq_strm,
  input  logic [`RDMA_LEN_BITS-1:0]       sq_len,
  input  logic [`VADDR_BITS-1:0]          sq_remote_vaddr,
  input  logic [`OFFS_BITS-1:0]           sq_remote_offs,
  input  logic [`LEN_BITS-1:0]            sq_remote_len,
  // Core send-queue word
  output logic                            core_sq_valid,
  output logic [`RDMA_REQ_BITS-1:0]       core_sq_data,
  // Core ack word
  input  logic                            core_ack_valid,
  input  logic [`RDMA_ACK_BITS-1:0]       core_ack_data,
  // User ack
  output logic                            ack_valid,
  output logic [`RDMA_OPCODE_BITS-1:0]    ack_opcode,
  output logic [`PID_BITS-1:0]            ack_pid,
  output logic [`DEST_BITS-1:0]           ack_vfid,
  output logic                            ack_host,
  output logic [`DEST_BITS-1:0]           ack_dest,
  output logic [`STRM_BITS-1:0]           ack_strm,
  output logic                            ack_last,
  output logic [`ECN_BITS-1:0]            ack_ecn,
  // Core read command
  input  logic                            core_rd_cmd_valid,
  input  logic [`RDMA_BASE_REQ_BITS-1:0]  core_rd_cmd_data,
  // Read request
  output logic                            rd_req_valid,
  output logic [`RDMA_OPCODE_BITS-1:0]    rd_req_opcode,
  output logic [`PID_BITS-1:0]            rd_req_pid,
  output logic [`DEST_BITS-1:0]           rd_req_vfid,
  output logic                            rd_req_last,
  output logic [`VADDR_BITS-1:0]          rd_req_vaddr,
  output logic [`DEST_BITS-1:0]           rd_req_dest,
  output logic [`STRM_BITS-1:0]           rd_req_strm,
  output logic [`LEN_BITS-1:0]            rd_req_len,
  output logic                            rd_req_actv,
  output logic                            rd_req_host,
  output logic [`OFFS_BITS-1:0]           rd_req_offs,
  // Core write command
  input  logic                            core_wr_cmd_valid,
  input  logic [`RDMA_BASE_REQ_BITS-1:0]  core_wr_cmd_data,
  // Write request
  output logic                            wr_req_valid,
  output logic [`RDMA_OPCODE_BITS-1:0]    wr_req_opcode,
  output logic [`PID_BITS-1:0]            wr_req_pid,
  output logic [`DEST_BITS-1:0]           wr_req_vfid,
  output logic                            wr_req_last,
  output logic [`VADDR_BITS-1:0]          wr_req_vaddr,
  output logic [`DEST_BITS-1:0]           wr_req_dest,
  output logic [`STRM_BITS-1:0]           wr_req_strm,
  output logic [`LEN_BITS-1:0]            wr_req_len,
  output logic                            wr_req_actv,
  output logic                            wr_req_host,
  output logic [`OFFS_BITS-1:0]           wr_req_offs
);

  // Input side, user request to core word
  sq_encoder inst_sq_encoder (
    .nclk            (nclk),
    .arst_n          (arst_n),
    .sq_valid        (sq_valid),
    .sq_opcode       (sq_opcode),
    .sq_pid          (sq_pid),
    .sq_vfid         (sq_vfid),
    .sq_host         (sq_host),
    .sq_last         (sq_last),
    .sq_offs         (sq_offs),
    .sq_vaddr        (sq_vaddr),
    .sq_dest         (sq_dest),
    .sq_len          (sq_len),
    .sq_strm         (sq_strm),
    .sq_remote_vaddr (sq_remote_vaddr),
    .sq_remote_offs  (sq_remote_offs),
    .sq_remote_len   (sq_remote_len),
    .core_sq_valid   (core_sq_valid),
    .core_sq_data    (core_sq_data)
  );

  // Read commands from the core
  mem_cmd_decoder inst_rd_cmd_decoder (
    .nclk       (nclk),
    .arst_n     (arst_n),
    .cmd_valid  (core_rd_cmd_valid),
    .cmd_data   (core_rd_cmd_data),
    .req_valid  (rd_req_valid),
    .req_opcode (rd_req_opcode),
    .req_pid    (rd_req_pid),
    .req_vfid   (rd_req_vfid),
    .req_last   (rd_req_last),
    .req_vaddr  (rd_req_vaddr),
    .req_dest   (rd_req_dest),
    .req_strm   (rd_req_strm),
    .req_len    (rd_req_len),
    .req_actv   (rd_req_actv),
    .req_host   (rd_req_host),
    .req_offs   (rd_req_offs)
  );

  // Write commands, same layout
  mem_cmd_decoder inst_wr_cmd_decoder (
    .nclk       (nclk),
    .arst_n     (arst_n),
    .cmd_valid  (core_wr_cmd_valid),
    .cmd_data   (core_wr_cmd_data),
    .req_valid  (wr_req_valid),
    .req_opcode (wr_req_opcode),
    .req_pid    (wr_req_pid),
    .req_vfid   (wr_req_vfid),
    .req_last   (wr_req_last),
    .req_vaddr  (wr_req_vaddr),
    .req_dest   (wr_req_dest),
    .req_strm   (wr_req_strm),
    .req_len    (wr_req_len),
    .req_actv   (wr_req_actv),
    .req_host   (wr_req_host),
    .req_offs   (wr_req_offs)
  );

  // Output side, core ack to user completion
  ack_decoder inst_ack_decoder (
    .nclk           (nclk),
    .arst_n         (arst_n),
    .core_ack_valid (core_ack_valid),
    .core_ack_data  (core_ack_data),
    .ack_valid      (ack_valid),
    .ack_opcode     (ack_opcode),
    .ack_pid        (ack_pid),
    .ack_vfid       (ack_vfid),
    .ack_host       (ack_host),
    .ack_dest       (ack_dest),
    .ack_strm       (ack_strm),
    .ack_last       (ack_last),
    .ack_ecn        (ack_ecn)
  );

endmodule

`default_nettype wire

// ==== sim/tb_clock.sv ====
// Testbench clock and reset source, 20 ns clock with reset held low for 16 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic nclk,
  output logic arst_n
);

  localparam int HALF_PERIOD  = 10;
  localparam int RESET_CYCLES = 16;

  initial begin
    nclk = 1'b0;
    forever begin
      #HALF_PERIOD nclk = ~nclk;
    end
  end

  // Low from time zero, released on a falling edge
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge nclk);
    @(negedge nclk);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== sim/roce_meta_props.sv ====
// Bound checks on the shim, strobe latency, reset state and send-queue pad bits
`timescale 1ns/1ps
`default_nettype none

`include "roce_meta_settings.svh"

module roce_meta_props (
  input logic                        nclk,
  input logic                        arst_n,
  input logic                        sq_valid,
  input logic                        core_ack_valid,
  input logic                        core_rd_cmd_valid,
  input logic                        core_wr_cmd_valid,
  input logic                        core_sq_valid,
  input logic [`RDMA_REQ_BITS-1:0]   core_sq_data,
  input logic                        ack_valid,
  input logic                        rd_req_valid,
  input logic                        wr_req_valid
);

  // Number of failed checks so far
  int error_count;

  // One register stage on every path
  assert property (@(posedge nclk) disable iff (!arst_n) core_sq_valid == $past(sq_valid))
    else begin
      error_count = error_count + 1;
      $error("core_sq_valid does not follow sq_valid by one cycle");
    end
  assert property (@(posedge nclk) disable iff (!arst_n) ack_valid == $past(core_ack_valid))
    else begin
      error_count = error_count + 1;
      $error("ack_valid does not follow core_ack_valid by one cycle");
    end
  assert property (@(posedge nclk) disable iff (!arst_n)
    rd_req_valid == $past(core_rd_cmd_valid))
    else begin
      error_count = error_count + 1;
      $error("rd_req_valid does not follow core_rd_cmd_valid by one cycle");
    end
  assert property (@(posedge nclk) disable iff (!arst_n)
    wr_req_valid == $past(core_wr_cmd_valid))
    else begin
      error_count = error_count + 1;
      $error("wr_req_valid does not follow core_wr_cmd_valid by one cycle");
    end

  // Pads below opcode end, above vfid, above local vaddr, above strm
  assert property (@(posedge nclk) disable iff (!arst_n)
    core_sq_valid |-> core_sq_data[31:5] == '0 && core_sq_data[55:42] == '0
                   && core_sq_data[127:112] == '0 && core_sq_data[191:182] == '0)
    else begin
      error_count = error_count + 1;
      $error("send-queue word has a pad bit set");
    end

  // First edge skipped, flops settle on it
  assert property (@(posedge nclk) !arst_n && $past(!arst_n)
    |-> !(core_sq_valid || ack_valid || rd_req_valid || wr_req_valid))
    else begin
      error_count = error_count + 1;
      $error("output valid high while in reset");
    end

endmodule

`default_nettype wire

// ==== sim/tb_roce_meta_shim.sv ====
// Testbench for the RoCE metadata shim with random traffic on all four paths
`timescale 1ns/1ps
`default_nettype none

`include "roce_meta_settings.svh"

module tb_roce_meta_shim;

  localparam int RESET_CYCLES   = 16;
  // Idle, send queue, ack, paired commands and all paths
  localparam int RUN_CYCLES     = 2 + 64 + 64 + 64 + 32;
  localparam int TIMEOUT_CYCLES = 8 * (RESET_CYCLES + RUN_CYCLES + 10);

  logic nclk;
  logic arst_n;
  logic sq_valid, sq_host, sq_last;
  logic [`RDMA_OPCODE_BITS-1:0] sq_opcode, ack_opcode, rd_req_opcode, wr_req_opcode;
  logic [`PID_BITS-1:0] sq_pid, ack_pid, rd_req_pid, wr_req_pid;
  logic [`DEST_BITS-1:0] sq_vfid, sq_dest, ack_vfid, ack_dest;
  logic [`DEST_BITS-1:0] rd_req_vfid, rd_req_dest, wr_req_vfid, wr_req_dest;
  logic [`STRM_BITS-1:0] sq_strm, ack_strm, rd_req_strm, wr_req_strm;
  logic [`OFFS_BITS-1:0] sq_offs, sq_remote_offs, rd_req_offs, wr_req_offs;
  logic [`VADDR_BITS-1:0] sq_vaddr, sq_remote_vaddr, rd_req_vaddr, wr_req_vaddr;
  logic [`RDMA_LEN_BITS-1:0] sq_len;
  logic [`LEN_BITS-1:0] sq_remote_len, rd_req_len, wr_req_len;
  logic core_sq_valid;
  logic [`RDMA_REQ_BITS-1:0] core_sq_data;
  logic core_ack_valid, ack_valid, ack_host, ack_last;
  logic [`RDMA_ACK_BITS-1:0] core_ack_data;
  logic [`ECN_BITS-1:0] ack_ecn;
  logic core_rd_cmd_valid, core_wr_cmd_valid;
  logic [`RDMA_BASE_REQ_BITS-1:0] core_rd_cmd_data, core_wr_cmd_data;
  logic rd_req_valid, rd_req_last, rd_req_actv, rd_req_host;
  logic wr_req_valid, wr_req_last, wr_req_actv, wr_req_host;

  // Expected values at drive time and one edge later
  logic [255:0] sq_exp, sq_exp_q;
  logic [23:0]  ack_exp, ack_exp_q, ack_got;
  logic [105:0] rd_exp, rd_exp_q, rd_got, wr_exp, wr_exp_q, wr_got;
  logic         sq_pend, ack_pend, rd_pend, wr_pend, any_out_valid;
  string        test_name, check_name;
  integer       seed;
  int           cycle_count;

  tb_clock clk_gen (
    .nclk   (nclk),
    .arst_n (arst_n)
  );

  roce_meta_shim dut (.*);

  bind roce_meta_shim roce_meta_props props (
    .nclk              (nclk),
    .arst_n            (arst_n),
    .sq_valid          (sq_valid),
    .core_ack_valid    (core_ack_valid),
    .core_rd_cmd_valid (core_rd_cmd_valid),
    .core_wr_cmd_valid (core_wr_cmd_valid),
    .core_sq_valid     (core_sq_valid),
    .core_sq_data      (core_sq_data),
    .ack_valid         (ack_valid),
    .rd_req_valid      (rd_req_valid),
    .wr_req_valid      (wr_req_valid)
  );

  assign ack_got = {ack_opcode, ack_pid, ack_vfid, ack_host, ack_dest, ack_strm, ack_last,
                    ack_ecn};
  assign rd_got  = {rd_req_opcode, rd_req_pid, rd_req_vfid, rd_req_last, rd_req_vaddr,
                    rd_req_dest, rd_req_strm, rd_req_len, rd_req_actv, rd_req_host, rd_req_offs};
  assign wr_got  = {wr_req_opcode, wr_req_pid, wr_req_vfid, wr_req_last, wr_req_vaddr,
                    wr_req_dest, wr_req_strm, wr_req_len, wr_req_actv, wr_req_host, wr_req_offs};
  assign any_out_valid = core_sq_valid | ack_valid | rd_req_valid | wr_req_valid;

  task automatic report_mismatch(input string name, input string exp, input string act);
    $display("[FAIL] %s expected %s actual %s", name, exp, act);
    $display("FAIL: see errors above");
    $fatal(1, "output mismatch");
  endtask

  task automatic report_failure(input string why);
    $display("ERROR: %s", why);
    $display("FAIL: see errors above");
    $fatal(1, "run stopped");
  endtask

  function automatic logic [255:0] random_word();
    logic [255:0] w;
    for (int i = 0; i < 8; i++) begin
      w[i*32 +: 32] = $random(seed);
    end
    return w;
  endfunction

  // Send-queue packing from the word layout
  function automatic logic [255:0] expected_sq_word();
    logic [255:0] w;
    w = '0;
    w[4:0]     = sq_opcode;
    w[37:32]   = sq_pid;
    w[41:38]   = sq_vfid;
    w[56]      = sq_host;
    w[57]      = sq_last;
    w[63:58]   = sq_offs;
    w[111:64]  = sq_vaddr;
    w[175:128] = sq_remote_vaddr;
    w[179:176] = sq_dest;
    w[181:180] = sq_strm;
    w[223:192] = sq_len;
    w[251:224] = sq_remote_len;
    // Only the low 4 bits of remote offs fit
    w[255:252] = sq_remote_offs[3:0];
    return w;
  endfunction

  function automatic logic [23:0] expected_ack(input logic [95:0] w);
    return {w[4:0], w[37:32], w[41:38], w[56], w[60:57], w[62:61], w[63], w[64]};
  endfunction

  // QPN pad at 42..55 never used
  function automatic logic [105:0] expected_cmd(input logic [159:0] w);
    return {w[4:0], w[37:32], w[41:38], w[56], w[104:57], w[108:105], w[110:109],
            w[138:111], w[139], w[140], w[146:141]};
  endfunction

  // One falling edge of stimulus with random contents on the enabled paths
  task automatic drive_cycle(input string name, input bit do_sq, input bit do_ack,
                             input bit do_rd, input bit do_wr);
    logic [255:0] w;
    @(negedge nclk);
    test_name         = name;
    sq_valid          = do_sq;
    core_ack_valid    = do_ack;
    core_rd_cmd_valid = do_rd;
    core_wr_cmd_valid = do_wr;
    if (do_sq) begin
      w = random_word();
      {sq_opcode, sq_pid, sq_vfid, sq_host, sq_last, sq_offs, sq_vaddr, sq_dest, sq_strm,
       sq_len, sq_remote_vaddr, sq_remote_offs, sq_remote_len} = w[190:0];
      sq_exp = expected_sq_word();
    end
    if (do_ack) begin
      w = random_word();
      core_ack_data = w[95:0];
      ack_exp = expected_ack(core_ack_data);
    end
    if (do_rd) begin
      w = random_word();
      core_rd_cmd_data = w[159:0];
      rd_exp = expected_cmd(core_rd_cmd_data);
    end
    if (do_wr) begin
      w = random_word();
      core_wr_cmd_data = w[159:0];
      wr_exp = expected_cmd(core_wr_cmd_data);
    end
  endtask

  // Expectations follow their strobe through one register stage
  always @(posedge nclk) begin
    sq_pend    <= sq_valid;
    ack_pend   <= core_ack_valid;
    rd_pend    <= core_rd_cmd_valid;
    wr_pend    <= core_wr_cmd_valid;
    sq_exp_q   <= sq_exp;
    ack_exp_q  <= ack_exp;
    rd_exp_q   <= rd_exp;
    wr_exp_q   <= wr_exp;
    check_name <= test_name;
  end

  // Outputs move only on rising edges and are sampled on falling ones
  // Data is zero after reset and holds the last strobe between strobes
  assert property (@(negedge nclk) disable iff (arst_n !== 1'b1)
    core_sq_valid == sq_pend && core_sq_data == sq_exp_q)
    else report_mismatch({check_name, " core_sq"},
      $sformatf("valid %b data %h", sq_pend, sq_exp_q),
      $sformatf("valid %b data %h", core_sq_valid, core_sq_data));
  assert property (@(negedge nclk) disable iff (arst_n !== 1'b1)
    ack_valid == ack_pend && ack_got == ack_exp_q)
    else report_mismatch({check_name, " ack"},
      $sformatf("valid %b fields %h", ack_pend, ack_exp_q),
      $sformatf("valid %b fields %h", ack_valid, ack_got));
  assert property (@(negedge nclk) disable iff (arst_n !== 1'b1)
    rd_req_valid == rd_pend && rd_got == rd_exp_q)
    else report_mismatch({check_name, " rd_req"},
      $sformatf("valid %b fields %h", rd_pend, rd_exp_q),
      $sformatf("valid %b fields %h", rd_req_valid, rd_got));
  assert property (@(negedge nclk) disable iff (arst_n !== 1'b1)
    wr_req_valid == wr_pend && wr_got == wr_exp_q)
    else report_mismatch({check_name, " wr_req"},
      $sformatf("valid %b fields %h", wr_pend, wr_exp_q),
      $sformatf("valid %b fields %h", wr_req_valid, wr_got));

  assert property (@(negedge nclk) !arst_n |-> !any_out_valid)
    else report_failure("an output valid was high during reset");
  assert property (@(posedge nclk) $rose(arst_n) |=> !any_out_valid)
    else report_failure("an output valid was high in the first cycle after reset");

  always @(negedge nclk) begin
    if (dut.props.error_count != 0) begin
      report_failure("a bound timing or pad check failed");
    end
  end

  always @(posedge nclk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      report_failure($sformatf("run hung, not finished after %0d cycles", TIMEOUT_CYCLES));
    end
  end

  initial begin
    seed              = 32'h3af3df2c;
    test_name         = "reset";
    sq_valid          = 1'b0;
    core_ack_valid    = 1'b0;
    core_rd_cmd_valid = 1'b0;
    core_wr_cmd_valid = 1'b0;
    {sq_opcode, sq_pid, sq_vfid, sq_host, sq_last, sq_offs, sq_vaddr, sq_dest, sq_strm,
     sq_len, sq_remote_vaddr, sq_remote_offs, sq_remote_len} = '0;
    core_ack_data    = '0;
    core_rd_cmd_data = '0;
    core_wr_cmd_data = '0;
    sq_exp           = '0;
    ack_exp          = '0;
    rd_exp           = '0;
    wr_exp           = '0;
    wait (arst_n === 1'b1);
    // Quiet right after release
    repeat (2) drive_cycle("reset", 1'b0, 1'b0, 1'b0, 1'b0);
    repeat (64) drive_cycle("sq_pack", 1'b1, 1'b0, 1'b0, 1'b0);
    repeat (64) drive_cycle("ack_decode", 1'b0, 1'b1, 1'b0, 1'b0);
    // Read and write together with random QPN pads
    repeat (64) drive_cycle("cmd_pair", 1'b0, 1'b0, 1'b1, 1'b1);
    repeat (32) drive_cycle("all_paths", 1'b1, 1'b1, 1'b1, 1'b1);
    repeat (3) drive_cycle("drain", 1'b0, 1'b0, 1'b0, 1'b0);
    if (dut.props.error_count == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1, "bound checks failed");
    end
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
src/roce_meta_pkg.sv
src/sq_encoder.sv
src/mem_cmd_decoder.sv
src/ack_decoder.sv
src/roce_meta_shim.sv
sim/tb_clock.sv
sim/roce_meta_props.sv
sim/tb_roce_meta_shim.sv

// ==== Makefile ====
# Verilator lint and simulation of the RoCE metadata shim

VERILATOR ?= verilator
TOP       ?= tb_roce_meta_shim
RTL_TOP   ?= roce_meta_shim
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= PASS: all tests
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# Pass only when the log holds the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
